/* addr_router.sv */
`timescale 1ns/1ps
`default_nettype none

`include "interconnect_settings.svh"

module addr_router import interconnect_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  frame_t istream_msg,
  input  logic   istream_val,
  output logic   istream_rdy,
  output data_t  ostream_msg [`ROUTER_OUTPUTS],
  output logic   ostream_val [`ROUTER_OUTPUTS],
  input  logic   ostream_rdy [`ROUTER_OUTPUTS]
);

  addr_t      addr;
  logic       in_range;
  logic       sel_rdy;
  // debug count of dropped frames, saturates
  logic [7:0] drop_cnt;

  assign addr     = istream_msg[`FRAME_BITS-1 -: `ADDR_BITS];
  assign in_range = int'(addr) < `ROUTER_OUTPUTS;

  always_comb begin
    sel_rdy = 1'b0;
    for (int i = 0; i < `ROUTER_OUTPUTS; i++) begin
      ostream_msg[i] = istream_msg[`DATA_BITS-1:0];
      ostream_val[i] = istream_val && (addr == addr_t'(i));
      if (addr == addr_t'(i)) begin
        sel_rdy = ostream_rdy[i];
      end
    end
  end

  // unknown addresses are swallowed right away
  assign istream_rdy = in_range ? sel_rdy : 1'b1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      drop_cnt <= '0;
    end else if (istream_val && !in_range && drop_cnt != '1) begin
      drop_cnt <= drop_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* blocking_xbar.sv */
`timescale 1ns/1ps
`default_nettype none

module blocking_xbar import interconnect_pkg::*; #(
  parameter int N_INPUTS  = 1,
  parameter int N_OUTPUTS = 2
) (
  input  logic  clk,
  input  logic  rst_n,
  input  data_t recv_msg [N_INPUTS],
  input  logic  recv_val [N_INPUTS],
  output logic  recv_rdy [N_INPUTS],
  output data_t send_msg [N_OUTPUTS],
  output logic  send_val [N_OUTPUTS],
  input  logic  send_rdy [N_OUTPUTS],
  input  ctrl_t control,
  input  logic  control_val,
  output logic  control_rdy
);

  localparam int N_PATHS = N_INPUTS * N_OUTPUTS;

  ctrl_t cfg;
  ctrl_t sel_in;
  ctrl_t sel_out;
  data_t path_msg;
  logic  path_val;
  logic  path_rdy;

  // out-of-range path indices leave the current path in place
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg <= '0;
    end else if (control_val && int'(control) < N_PATHS) begin
      cfg <= control;
    end
  end

  assign control_rdy = 1'b1;

  assign sel_in  = ctrl_t'(int'(cfg) / N_OUTPUTS);
  assign sel_out = ctrl_t'(int'(cfg) % N_OUTPUTS);

  // pick the active input
  always_comb begin
    path_msg = '0;
    path_val = 1'b0;
    for (int i = 0; i < N_INPUTS; i++) begin
      if (sel_in == ctrl_t'(i)) begin
        path_msg = recv_msg[i];
        path_val = recv_val[i];
      end
    end
  end

  // pick the active output's ready
  always_comb begin
    path_rdy = 1'b0;
    for (int o = 0; o < N_OUTPUTS; o++) begin
      if (sel_out == ctrl_t'(o)) begin
        path_rdy = send_rdy[o];
      end
    end
  end

  always_comb begin
    for (int o = 0; o < N_OUTPUTS; o++) begin
      send_msg[o] = path_msg;
      send_val[o] = path_val && (sel_out == ctrl_t'(o));
    end
    for (int i = 0; i < N_INPUTS; i++) begin
      recv_rdy[i] = path_rdy && (sel_in == ctrl_t'(i));
    end
  end

endmodule

`default_nettype wire

/* interconnect_pkg.sv */
`default_nettype none

`include "interconnect_settings.svh"

package interconnect_pkg;

  // raw SPI frame as shifted in or out
  typedef logic [`FRAME_BITS-1:0] frame_t;

  // sample or payload word
  typedef logic [`DATA_BITS-1:0] data_t;

  // router address field
  typedef logic [`ADDR_BITS-1:0] addr_t;

  // crossbar path index, low payload bits of a config frame
  typedef logic [3:0] ctrl_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SHIFT,
    ST_DONE
  } minion_state_t;

endpackage

`default_nettype wire

/* interconnect_settings.svh */
`ifndef INTERCONNECT_SETTINGS_SVH
`define INTERCONNECT_SETTINGS_SVH

// one SPI frame: address on top, payload below
`define FRAME_BITS 20

// payload carried by every stream
`define DATA_BITS 16

// address field sits in frame bits 19:16
`define ADDR_BITS 4

// streams leaving the address router
`define ROUTER_OUTPUTS 4

// flops between the SPI pins and the clk domain
`define SYNC_STAGES 2

`endif

/* interconnect_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "interconnect_settings.svh"

module interconnect_top import interconnect_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic cs,
  input  logic sclk,
  input  logic mosi,
  output logic miso
);

  frame_t spi_recv_msg;
  logic   spi_recv_val;
  logic   spi_recv_rdy;

  data_t  router_msg [`ROUTER_OUTPUTS];
  logic   router_val [`ROUTER_OUTPUTS];
  logic   router_rdy [`ROUTER_OUTPUTS];

  data_t  in_xbar_recv_msg [1];
  logic   in_xbar_recv_val [1];
  logic   in_xbar_recv_rdy [1];
  // output 0 is bypass, output 1 the averager
  data_t  in_xbar_send_msg [2];
  logic   in_xbar_send_val [2];
  logic   in_xbar_send_rdy [2];
  ctrl_t  in_ctrl;
  logic   in_ctrl_val;
  logic   in_ctrl_rdy;

  // inputs are loopback, bypass, averager
  data_t  out_xbar_recv_msg [3];
  logic   out_xbar_recv_val [3];
  logic   out_xbar_recv_rdy [3];
  data_t  out_xbar_send_msg [1];
  logic   out_xbar_send_val [1];
  logic   out_xbar_send_rdy [1];
  ctrl_t  out_ctrl;
  logic   out_ctrl_val;
  logic   out_ctrl_rdy;

  spi_minion i_spi_minion (
    .clk      (clk),
    .rst_n    (rst_n),
    .cs       (cs),
    .sclk     (sclk),
    .mosi     (mosi),
    .miso     (miso),
    .recv_msg (spi_recv_msg),
    .recv_val (spi_recv_val),
    .recv_rdy (spi_recv_rdy),
    .send_msg (out_xbar_send_msg[0]),
    .send_val (out_xbar_send_val[0]),
    .send_rdy (out_xbar_send_rdy[0])
  );

  addr_router i_addr_router (
    .clk         (clk),
    .rst_n       (rst_n),
    .istream_msg (spi_recv_msg),
    .istream_val (spi_recv_val),
    .istream_rdy (spi_recv_rdy),
    .ostream_msg (router_msg),
    .ostream_val (router_val),
    .ostream_rdy (router_rdy)
  );

  // address 0 is data into the input crossbar
  assign in_xbar_recv_msg[0] = router_msg[0];
  assign in_xbar_recv_val[0] = router_val[0];
  assign router_rdy[0]       = in_xbar_recv_rdy[0];

  // address 1 loops straight to the output crossbar
  assign out_xbar_recv_msg[0] = router_msg[1];
  assign out_xbar_recv_val[0] = router_val[1];
  assign router_rdy[1]        = out_xbar_recv_rdy[0];

  // addresses 2 and 3 configure the crossbars
  assign in_ctrl       = router_msg[2][3:0];
  assign in_ctrl_val   = router_val[2];
  assign router_rdy[2] = in_ctrl_rdy;
  assign out_ctrl      = router_msg[3][3:0];
  assign out_ctrl_val  = router_val[3];
  assign router_rdy[3] = out_ctrl_rdy;

  blocking_xbar #(
    .N_INPUTS  (1),
    .N_OUTPUTS (2)
  ) input_xbar (
    .clk         (clk),
    .rst_n       (rst_n),
    .recv_msg    (in_xbar_recv_msg),
    .recv_val    (in_xbar_recv_val),
    .recv_rdy    (in_xbar_recv_rdy),
    .send_msg    (in_xbar_send_msg),
    .send_val    (in_xbar_send_val),
    .send_rdy    (in_xbar_send_rdy),
    .control     (in_ctrl),
    .control_val (in_ctrl_val),
    .control_rdy (in_ctrl_rdy)
  );

  assign out_xbar_recv_msg[1] = in_xbar_send_msg[0];
  assign out_xbar_recv_val[1] = in_xbar_send_val[0];
  assign in_xbar_send_rdy[0]  = out_xbar_recv_rdy[1];

  sample_averager i_sample_averager (
    .clk      (clk),
    .rst_n    (rst_n),
    .recv_msg (in_xbar_send_msg[1]),
    .recv_val (in_xbar_send_val[1]),
    .recv_rdy (in_xbar_send_rdy[1]),
    .send_msg (out_xbar_recv_msg[2]),
    .send_val (out_xbar_recv_val[2]),
    .send_rdy (out_xbar_recv_rdy[2])
  );

  blocking_xbar #(
    .N_INPUTS  (3),
    .N_OUTPUTS (1)
  ) output_xbar (
    .clk         (clk),
    .rst_n       (rst_n),
    .recv_msg    (out_xbar_recv_msg),
    .recv_val    (out_xbar_recv_val),
    .recv_rdy    (out_xbar_recv_rdy),
    .send_msg    (out_xbar_send_msg),
    .send_val    (out_xbar_send_val),
    .send_rdy    (out_xbar_send_rdy),
    .control     (out_ctrl),
    .control_val (out_ctrl_val),
    .control_rdy (out_ctrl_rdy)
  );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_interconnect -f src.f -o tb_interconnect
./obj_dir/tb_interconnect

/* sample_averager.sv */
`timescale 1ns/1ps
`default_nettype none

`include "interconnect_settings.svh"

module sample_averager import interconnect_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  data_t recv_msg,
  input  logic  recv_val,
  output logic  recv_rdy,
  output data_t send_msg,
  output logic  send_val,
  input  logic  send_rdy
);

  // the three samples before the newest one
  data_t                 hist [3];
  logic [`DATA_BITS+1:0] sum;
  logic                  take;

  assign recv_rdy = ~send_val | send_rdy;
  assign take     = recv_val & recv_rdy;

  // two extra bits hold the sum of four samples
  assign sum = {2'b00, recv_msg} + {2'b00, hist[0]} + {2'b00, hist[1]} + {2'b00, hist[2]};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 3; i++) begin
        hist[i] <= '0;
      end
    end else if (take) begin
      hist[0] <= recv_msg;
      hist[1] <= hist[0];
      hist[2] <= hist[1];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      send_val <= 1'b0;
    end else if (take) begin
      send_val <= 1'b1;
    end else if (send_rdy) begin
      send_val <= 1'b0;
    end
  end

  // divide by four, truncated
  always_ff @(posedge clk) begin
    if (take) begin
      send_msg <= sum[`DATA_BITS+1:2];
    end
  end

endmodule

`default_nettype wire

/* spi_minion.sv */
`timescale 1ns/1ps
`default_nettype none

`include "interconnect_settings.svh"

module spi_minion import interconnect_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   cs,
  input  logic   sclk,
  input  logic   mosi,
  output logic   miso,
  output frame_t recv_msg,
  output logic   recv_val,
  input  logic   recv_rdy,
  input  data_t  send_msg,
  input  logic   send_val,
  output logic   send_rdy
);

  localparam int CNT_BITS = $clog2(`FRAME_BITS + 2);
  localparam int PAD_BITS = `FRAME_BITS - `DATA_BITS - 2;

  // {cs, sclk, mosi} move through one chain so they stay aligned
  logic [2:0] pin_sync [`SYNC_STAGES];
  logic       cs_s;
  logic       sclk_s;
  logic       mosi_s;
  logic       cs_q;
  logic       sclk_q;
  logic       cs_fall;
  logic       cs_rise;
  logic       sclk_rise;
  logic       sclk_fall;
  logic       frame_start;

  minion_state_t       state;
  logic [CNT_BITS-1:0] bit_cnt;
  frame_t              rx_shift;
  frame_t              tx_shift;

  // one-entry holding registers on each side
  frame_t recv_data;
  logic   recv_full;
  data_t  resp_data;
  logic   resp_full;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `SYNC_STAGES; i++) begin
        pin_sync[i] <= 3'b100;
      end
      cs_q   <= 1'b1;
      sclk_q <= 1'b0;
    end else begin
      pin_sync[0] <= {cs, sclk, mosi};
      for (int i = 1; i < `SYNC_STAGES; i++) begin
        pin_sync[i] <= pin_sync[i-1];
      end
      cs_q   <= cs_s;
      sclk_q <= sclk_s;
    end
  end

  assign {cs_s, sclk_s, mosi_s} = pin_sync[`SYNC_STAGES-1];

  assign cs_fall     = cs_q & ~cs_s;
  assign cs_rise     = ~cs_q & cs_s;
  // sclk edges only count while selected
  assign sclk_rise   = sclk_s & ~sclk_q & ~cs_s;
  assign sclk_fall   = ~sclk_s & sclk_q & ~cs_s;
  assign frame_start = (state == ST_IDLE) && cs_fall;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      bit_cnt  <= '0;
      tx_shift <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (frame_start) begin
            state    <= ST_SHIFT;
            bit_cnt  <= '0;
            // status bits, then the pending response if any
            tx_shift <= {{PAD_BITS{1'b0}}, ~recv_full, resp_full,
                         resp_full ? resp_data : data_t'(0)};
          end
        end
        ST_SHIFT: begin
          if (cs_rise) begin
            // short or long frames are thrown away
            state <= (bit_cnt == CNT_BITS'(`FRAME_BITS)) ? ST_DONE : ST_IDLE;
          end else begin
            if (sclk_rise && bit_cnt <= CNT_BITS'(`FRAME_BITS)) begin
              bit_cnt <= bit_cnt + 1'b1;
            end
            if (sclk_fall) begin
              tx_shift <= {tx_shift[`FRAME_BITS-2:0], 1'b0};
            end
          end
        end
        ST_DONE: begin
          state <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_SHIFT && sclk_rise) begin
      rx_shift <= {rx_shift[`FRAME_BITS-2:0], mosi_s};
    end
  end

  // a frame arriving while the register is full is lost
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      recv_full <= 1'b0;
    end else if (state == ST_DONE && !recv_full) begin
      recv_full <= 1'b1;
    end else if (recv_val && recv_rdy) begin
      recv_full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_DONE && !recv_full) begin
      recv_data <= rx_shift;
    end
  end

  // the response leaves on the next frame start
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_full <= 1'b0;
    end else if (send_val && send_rdy) begin
      resp_full <= 1'b1;
    end else if (frame_start) begin
      resp_full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (send_val && send_rdy) begin
      resp_data <= send_msg;
    end
  end

  assign miso     = tx_shift[`FRAME_BITS-1];
  assign recv_msg = recv_data;
  assign recv_val = recv_full;
  assign send_rdy = ~resp_full;

endmodule

`default_nettype wire

/* src.f */
+incdir+.
interconnect_pkg.sv
spi_minion.sv
addr_router.sv
blocking_xbar.sv
sample_averager.sv
interconnect_top.sv
tb_interconnect.sv

/* tb_interconnect.sv */
`timescale 1ns/1ps
`default_nettype none

`include "interconnect_settings.svh"

module tb_interconnect import interconnect_pkg::*; ();

  // clk cycles per sclk phase
  localparam int HALF_SCLK  = 4;
  // idle clk cycles with cs high between frames
  localparam int FRAME_GAP  = 8;
  localparam int POLL_LIMIT = 16;

  localparam int RECV_READY_BIT = 17;
  localparam int RESP_VALID_BIT = 16;

  localparam addr_t ADDR_DATA     = 4'd0;
  localparam addr_t ADDR_LOOPBACK = 4'd1;
  localparam addr_t ADDR_IN_CFG   = 4'd2;
  localparam addr_t ADDR_OUT_CFG  = 4'd3;
  localparam addr_t ADDR_POLL     = 4'd15;

  logic clk;
  logic rst_n;
  logic cs;
  logic sclk;
  logic mosi;
  logic miso;

  logic [15:0] lfsr_state;
  // samples already sent into the averager, newest first
  data_t       avg_window [3];

  interconnect_top i_interconnect_top (
    .clk   (clk),
    .rst_n (rst_n),
    .cs    (cs),
    .sclk  (sclk),
    .mosi  (mosi),
    .miso  (miso)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h",
               $time, name, got, expected);
      $display("Test failures found");
      $fatal(1, "value check failed");
    end
  endtask

  // taps of x^16 + x^14 + x^13 + x^11 + 1 with one step per bit
  function automatic data_t random_word();
    data_t word;
    logic  fb;
    word = '0;
    for (int i = 0; i < `DATA_BITS; i++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      word = {word[`DATA_BITS-2:0], fb};
    end
    return word;
  endfunction

  // SPI host shifting MSB first and reading miso just before each sclk rise
  task automatic spi_xfer(input frame_t tx, output frame_t rx);
    rx = '0;
    cs = 1'b0;
    for (int i = `FRAME_BITS-1; i >= 0; i--) begin
      mosi = tx[i];
      wait_cycles(HALF_SCLK);
      rx[i] = miso;
      sclk = 1'b1;
      wait_cycles(HALF_SCLK);
      sclk = 1'b0;
    end
    wait_cycles(HALF_SCLK);
    cs   = 1'b1;
    mosi = 1'b0;
    wait_cycles(FRAME_GAP);
  endtask

  // every frame here starts with the receive register empty
  task automatic send_frame(input addr_t addr, input data_t data, output frame_t rx);
    spi_xfer({addr, data}, rx);
    check_value("miso[19:18]", 32'(rx[19:18]), 32'd0);
    check_value("miso[17] recv_ready", 32'(rx[RECV_READY_BIT]), 32'd1);
  endtask

  task automatic spi_poll(output data_t data);
    frame_t rx;
    int     tries;
    logic   got;
    tries = 0;
    got   = 1'b0;
    rx    = '0;
    while (!got) begin
      if (tries == POLL_LIMIT) begin
        $display("Test failures found");
        $fatal(1, "no response seen after %0d polls", POLL_LIMIT);
      end
      send_frame(ADDR_POLL, '0, rx);
      tries++;
      got = rx[RESP_VALID_BIT];
    end
    data = rx[`DATA_BITS-1:0];
  endtask

  task automatic average_sample(input data_t sample);
    frame_t      rx;
    data_t       reply;
    logic [17:0] total;
    data_t       expected;
    total = 18'(sample) + 18'(avg_window[0]) + 18'(avg_window[1]) + 18'(avg_window[2]);
    // truncated mean of the last four samples
    expected = data_t'(total / 4);
    avg_window[2] = avg_window[1];
    avg_window[1] = avg_window[0];
    avg_window[0] = sample;
    send_frame(ADDR_DATA, sample, rx);
    spi_poll(reply);
    check_value("averager reply", 32'(reply), 32'(expected));
  endtask

  task automatic test_loopback();
    frame_t rx;
    data_t  sample;
    data_t  reply;
    // nothing sent yet, so no response may be pending
    send_frame(ADDR_POLL, '0, rx);
    check_value("miso[16] resp_valid", 32'(rx[RESP_VALID_BIT]), 32'd0);
    sample = random_word();
    send_frame(ADDR_LOOPBACK, sample, rx);
    check_value("miso[16] resp_valid", 32'(rx[RESP_VALID_BIT]), 32'd0);
    spi_poll(reply);
    check_value("loopback reply", 32'(reply), 32'(sample));
  endtask

  task automatic test_bypass();
    frame_t rx;
    data_t  sample;
    data_t  reply;
    send_frame(ADDR_OUT_CFG, 16'd1, rx);
    send_frame(ADDR_IN_CFG, 16'd0, rx);
    for (int n = 0; n < 5; n++) begin
      sample = random_word();
      send_frame(ADDR_DATA, sample, rx);
      spi_poll(reply);
      check_value("bypass reply", 32'(reply), 32'(sample));
    end
  endtask

  task automatic test_averager();
    frame_t rx;
    send_frame(ADDR_IN_CFG, 16'd1, rx);
    send_frame(ADDR_OUT_CFG, 16'd2, rx);
    for (int n = 0; n < 6; n++) begin
      average_sample(random_word());
    end
    // full-scale samples carry into the top sum bits
    for (int n = 0; n < 4; n++) begin
      average_sample(16'hFFFF);
    end
  endtask

  task automatic test_ignored_cfg();
    frame_t rx;
    // index 7 is past the 3 output crossbar paths
    send_frame(ADDR_OUT_CFG, 16'd7, rx);
    // low nibble 6 is past the 2 input crossbar paths
    send_frame(ADDR_IN_CFG, 16'hFFF6, rx);
    average_sample(random_word());
    for (int a = 4; a < 15; a++) begin
      send_frame(addr_t'(a), random_word(), rx);
      send_frame(ADDR_POLL, '0, rx);
      check_value("miso[16] resp_valid", 32'(rx[RESP_VALID_BIT]), 32'd0);
    end
  endtask

  task automatic test_backpressure();
    frame_t rx;
    data_t  first;
    data_t  second;
    data_t  reply;
    send_frame(ADDR_OUT_CFG, 16'd0, rx);
    first  = random_word();
    second = random_word();
    send_frame(ADDR_LOOPBACK, first, rx);
    check_value("miso[16] resp_valid", 32'(rx[RESP_VALID_BIT]), 32'd0);
    // the second frame carries the first reply back out
    send_frame(ADDR_LOOPBACK, second, rx);
    check_value("miso[16] resp_valid", 32'(rx[RESP_VALID_BIT]), 32'd1);
    check_value("first loopback reply", 32'(rx[`DATA_BITS-1:0]), 32'(first));
    spi_poll(reply);
    check_value("second loopback reply", 32'(reply), 32'(second));
    send_frame(ADDR_POLL, '0, rx);
    check_value("miso[16] resp_valid", 32'(rx[RESP_VALID_BIT]), 32'd0);
  endtask

  initial begin
    rst_n = 1'b0;
    cs    = 1'b1;
    sclk  = 1'b0;
    mosi  = 1'b0;
    lfsr_state = 16'd61;
    for (int i = 0; i < 3; i++) begin
      avg_window[i] = '0;
    end
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    wait_cycles(4);

    test_loopback();
    test_bypass();
    test_averager();
    test_ignored_cfg();
    test_backpressure();

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire
